//--- common/mipsPkg.sv
// shared word sizes, opcode, funct and ALU encodings; imported by every core module and the testbench
`default_nettype none

package mipsPkg;

  // ====================
  // sizes
  // ====================
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int memWords     = 64;

  // ====================
  // instruction fields
  // ====================

  // major opcodes, instr[31:26]
  typedef enum logic [5:0] {
    opRType = 6'b000000,
    opBeq   = 6'b000100,
    opAddi  = 6'b001000,
    opLw    = 6'b100011,
    opSw    = 6'b101011
  } opcodeT;

  // R-type functions, instr[5:0]
  typedef enum logic [5:0] {
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnOr  = 6'b100101,
    fnSlt = 6'b101010
  } functT;

  // ====================
  // ALU encodings
  // ====================

  // class handed from the main decode to the funct decode
  typedef enum logic [1:0] {
    aluAdd   = 2'b00,
    aluSub   = 2'b01,
    aluFunct = 2'b10
  } aluOpT;

  // bit 2 selects subtract / invert of b
  typedef enum logic [2:0] {
    ctrlAnd = 3'b000,
    ctrlOr  = 3'b001,
    ctrlAdd = 3'b010,
    ctrlSub = 3'b110,
    ctrlSlt = 3'b111
  } aluCtrlT;

endpackage

`default_nettype wire

//--- control/controlUnit.sv
// decodes opcode and funct of the current instruction into the core's control levels
`timescale 1ns/1ps
`default_nettype none

module controlUnit
  import mipsPkg::*;
(
  input  opcodeT  opcode,
  input  functT   funct,
  output logic    regWrite,
  output logic    regDst,
  output logic    aluSrc,
  output logic    branch,
  output logic    memWrite,
  output logic    memToReg,
  output aluCtrlT aluCtrl
);

  // levels from the main decode, before the funct check
  logic  decRegWrite;
  logic  decRegDst;
  logic  decAluSrc;
  logic  decBranch;
  logic  decMemWrite;
  logic  decMemToReg;
  aluOpT aluOp;

  aluCtrlT functCtrl;
  logic    functKnown;
  logic    instrValid;

  // ====================
  // main decode
  // ====================
  always_comb begin
    decRegWrite = 1'b0;
    decRegDst   = 1'b0;
    decAluSrc   = 1'b0;
    decBranch   = 1'b0;
    decMemWrite = 1'b0;
    decMemToReg = 1'b0;
    aluOp       = aluAdd;
    case (opcode)
      opRType: begin
        decRegWrite = 1'b1;
        decRegDst   = 1'b1;
        aluOp       = aluFunct;
      end
      opLw: begin
        decRegWrite = 1'b1;
        decAluSrc   = 1'b1;
        decMemToReg = 1'b1;
      end
      opSw: begin
        decAluSrc   = 1'b1;
        decMemWrite = 1'b1;
      end
      opBeq: begin
        decBranch = 1'b1;
        aluOp     = aluSub;
      end
      opAddi: begin
        decRegWrite = 1'b1;
        decAluSrc   = 1'b1;
      end
      // anything else runs as a nop
      default: ;
    endcase
  end

  // ====================
  // funct decode
  // ====================
  always_comb begin
    functKnown = 1'b1;
    case (funct)
      fnAdd:   functCtrl = ctrlAdd;
      fnSub:   functCtrl = ctrlSub;
      fnAnd:   functCtrl = ctrlAnd;
      fnOr:    functCtrl = ctrlOr;
      fnSlt:   functCtrl = ctrlSlt;
      default: begin
        functCtrl  = ctrlAdd;
        functKnown = 1'b0;
      end
    endcase
  end

  // an R-type with an unknown funct is dropped like an unknown opcode
  assign instrValid = (aluOp != aluFunct) || functKnown;

  always_comb begin
    case (aluOp)
      aluSub:   aluCtrl = ctrlSub;
      aluFunct: aluCtrl = functCtrl;
      default:  aluCtrl = ctrlAdd;
    endcase
  end

  assign regWrite = decRegWrite & instrValid;
  assign regDst   = decRegDst & instrValid;
  assign aluSrc   = decAluSrc & instrValid;
  assign branch   = decBranch & instrValid;
  assign memWrite = decMemWrite & instrValid;
  assign memToReg = decMemToReg & instrValid;

endmodule

`default_nettype wire

//--- datapath/registerFile.sv
// 32-entry register file, two combinational read ports and one clocked write port
`timescale 1ns/1ps
`default_nettype none

module registerFile
  import mipsPkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [regAddrWidth-1:0] readAddrA,
  input  logic [regAddrWidth-1:0] readAddrB,
  input  logic [regAddrWidth-1:0] writeAddr,
  input  logic                    writeEnable,
  input  logic [dataWidth-1:0]    writeData,
  output logic [dataWidth-1:0]    readDataA,
  output logic [dataWidth-1:0]    readDataB
);

  localparam int numRegs = 2 ** regAddrWidth;

  logic [dataWidth-1:0] regs [numRegs];

  // ====================
  // write port
  // ====================
  // r0 is never written, so it keeps its reset value of zero
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // ====================
  // read ports
  // ====================
  // a write in this cycle shows up only after the edge
  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

//--- datapath/alu.sv
// arithmetic and logic unit for add, sub, and, or and slt, with a zero flag for beq
`timescale 1ns/1ps
`default_nettype none

module alu
  import mipsPkg::*;
(
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  aluCtrlT              aluCtrl,
  output logic [dataWidth-1:0] y,
  output logic                 zero
);

  logic [dataWidth-1:0] sum;
  logic [dataWidth-1:0] diff;
  logic                 lessThan;

  assign sum  = a + b;
  assign diff = a - b;

  // signed compare
  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (aluCtrl)
      ctrlAnd: y = a & b;
      ctrlOr:  y = a | b;
      ctrlAdd: y = sum;
      ctrlSub: y = diff;
      ctrlSlt: y = {{(dataWidth-1){1'b0}}, lessThan};
      default: y = sum;
    endcase
  end

  // used by beq, which runs the ALU as a subtract
  assign zero = (y == '0);

endmodule

`default_nettype wire

//--- datapath/dataPath.sv
// PC, register file, ALU and the operand, write-back and next-PC selection of the single-cycle core
`timescale 1ns/1ps
`default_nettype none

module dataPath
  import mipsPkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [dataWidth-1:0]    instr,
  input  logic                    regWrite,
  input  logic                    regDst,
  input  logic                    aluSrc,
  input  logic                    branch,
  input  logic                    memToReg,
  input  aluCtrlT                 aluCtrl,
  input  logic [dataWidth-1:0]    readData,
  output logic [dataWidth-1:0]    pc,
  output logic [dataWidth-1:0]    aluResult,
  output logic [dataWidth-1:0]    writeData,
  output logic [dataWidth-1:0]    result,
  output logic [regAddrWidth-1:0] writeReg
);

  // instruction fields
  logic [regAddrWidth-1:0] rs;
  logic [regAddrWidth-1:0] rt;
  logic [regAddrWidth-1:0] rd;
  logic [15:0]             imm;

  logic [dataWidth-1:0] signImm;
  logic [dataWidth-1:0] readDataA;
  logic [dataWidth-1:0] readDataB;
  logic [dataWidth-1:0] srcB;
  logic                 zero;

  logic [dataWidth-1:0] pcPlus4;
  logic [dataWidth-1:0] branchTarget;
  logic [dataWidth-1:0] pcNext;
  logic                 pcSrc;

  assign rs  = instr[25:21];
  assign rt  = instr[20:16];
  assign rd  = instr[15:11];
  assign imm = instr[15:0];

  assign signImm = {{(dataWidth-16){imm[15]}}, imm};

  // ====================
  // register file and ALU
  // ====================
  assign writeReg = regDst ? rd : rt;

  registerFile regFile (
    .clk         (clk),
    .rstN        (rstN),
    .readAddrA   (rs),
    .readAddrB   (rt),
    .writeAddr   (writeReg),
    .writeEnable (regWrite),
    .writeData   (result),
    .readDataA   (readDataA),
    .readDataB   (readDataB)
  );

  assign srcB = aluSrc ? signImm : readDataB;

  alu mainAlu (
    .a       (readDataA),
    .b       (srcB),
    .aluCtrl (aluCtrl),
    .y       (aluResult),
    .zero    (zero)
  );

  // store data is always the rt read
  assign writeData = readDataB;

  // write-back select
  assign result = memToReg ? readData : aluResult;

  // ====================
  // next PC
  // ====================
  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pcPlus4 + {signImm[dataWidth-3:0], 2'b00};
  assign pcSrc        = branch & zero;
  assign pcNext       = pcSrc ? branchTarget : pcPlus4;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

//--- source/dataMemory.sv
// word-addressed data RAM for lw and sw, combinational read and clocked write
`timescale 1ns/1ps
`default_nettype none

module dataMemory
  import mipsPkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 writeEnable,
  input  logic [dataWidth-1:0] addr,
  input  logic [dataWidth-1:0] writeData,
  output logic [dataWidth-1:0] readData
);

  logic [dataWidth-1:0]         mem [memWords];
  logic [$clog2(memWords)-1:0] wordIndex;

  // byte address to word index; upper bits wrap
  assign wordIndex = addr[$clog2(memWords)+1:2];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < memWords; i++) begin
        mem[i] <= '0;
      end
    end else if (writeEnable) begin
      mem[wordIndex] <= writeData;
    end
  end

  assign readData = mem[wordIndex];

endmodule

`default_nettype wire

//--- source/mipsCore.sv
// top level of the single-cycle core; the testbench feeds instr for the current pc
`timescale 1ns/1ps
`default_nettype none

module mipsCore
  import mipsPkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [dataWidth-1:0]    instr,
  output logic [dataWidth-1:0]    pc,
  output logic                    regWrite,
  output logic [regAddrWidth-1:0] writeReg,
  output logic [dataWidth-1:0]    result,
  output logic                    memWrite,
  output logic [dataWidth-1:0]    dataAddr,
  output logic [dataWidth-1:0]    writeData
);

  logic                 regDst;
  logic                 aluSrc;
  logic                 branch;
  logic                 memToReg;
  aluCtrlT              aluCtrl;
  logic [dataWidth-1:0] readData;

  controlUnit ctrl (
    .opcode   (opcodeT'(instr[31:26])),
    .funct    (functT'(instr[5:0])),
    .regWrite (regWrite),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .branch   (branch),
    .memWrite (memWrite),
    .memToReg (memToReg),
    .aluCtrl  (aluCtrl)
  );

  dataPath dp (
    .clk       (clk),
    .rstN      (rstN),
    .instr     (instr),
    .regWrite  (regWrite),
    .regDst    (regDst),
    .aluSrc    (aluSrc),
    .branch    (branch),
    .memToReg  (memToReg),
    .aluCtrl   (aluCtrl),
    .readData  (readData),
    .pc        (pc),
    .aluResult (dataAddr),
    .writeData (writeData),
    .result    (result),
    .writeReg  (writeReg)
  );

  dataMemory dmem (
    .clk         (clk),
    .rstN        (rstN),
    .writeEnable (memWrite),
    .addr        (dataAddr),
    .writeData   (writeData),
    .readData    (readData)
  );

endmodule

`default_nettype wire

//--- tests/mipsCoreTb.sv
// testbench for mipsCore; plays the program from the trace file and checks pc and both write ports each cycle
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb
  import mipsPkg::*;
();

  localparam int    clkPeriod    = 40;
  localparam int    driveDelay   = 1;
  localparam int    resetCycles  = 4;
  localparam int    resetTimeout = 8;
  localparam int    maxCycles    = 200;
  localparam int    progWords    = 64;
  localparam int    progAddrBits = $clog2(progWords);
  localparam string traceFile    = "tests/programTrace.txt";

  logic                    clk;
  logic                    rstN;
  logic [dataWidth-1:0]    instr;
  logic [dataWidth-1:0]    pc;
  logic                    regWrite;
  logic [regAddrWidth-1:0] writeReg;
  logic [dataWidth-1:0]    result;
  logic                    memWrite;
  logic [dataWidth-1:0]    dataAddr;
  logic [dataWidth-1:0]    writeData;

  // program image by word address, then one expected record per executed cycle
  logic [dataWidth-1:0] progImage [progWords];
  logic [31:0] expPc[$];
  logic [31:0] expRegWrite[$];
  logic [31:0] expWriteReg[$];
  logic [31:0] expResult[$];
  logic [31:0] expMemWrite[$];
  logic [31:0] expDataAddr[$];
  logic [31:0] expWriteData[$];

  int errorCount = 0;
  int failCount  = 0;
  int checkCount = 0;
  int cycleIdx   = 0;

  mipsCore UUT (
    .clk       (clk),
    .rstN      (rstN),
    .instr     (instr),
    .pc        (pc),
    .regWrite  (regWrite),
    .writeReg  (writeReg),
    .result    (result),
    .memWrite  (memWrite),
    .dataAddr  (dataAddr),
    .writeData (writeData)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // ====================
  // trace loading
  // ====================
  task automatic loadTrace(output bit ok);
    int          fd;
    int          status;
    int          fields;
    string       line;
    logic [31:0] wordAddr;
    logic [31:0] word;
    logic [31:0] fPc;
    logic [31:0] fRegWrite;
    logic [31:0] fWriteReg;
    logic [31:0] fResult;
    logic [31:0] fMemWrite;
    logic [31:0] fDataAddr;
    logic [31:0] fWriteData;
    ok = 1'b0;
    // words outside the program hold an unknown opcode tagged with their address
    for (int i = 0; i < progWords; i++) begin
      progImage[i] = {6'h3f, 26'(i)};
    end
    fd = $fopen(traceFile, "r");
    if (fd == 0) begin
      $display("could not open the trace file %s", traceFile);
      failCount++;
      return;
    end
    while (!$feof(fd)) begin
      status = $fgets(line, fd);
      if (status == 0 || line.len() < 2) begin
        continue;
      end
      if (line[0] == "P") begin
        fields = $sscanf(line, "P %h %h", wordAddr, word);
        if (fields == 2 && wordAddr < progWords) begin
          progImage[wordAddr[progAddrBits-1:0]] = word;
        end else begin
          $display("malformed program line in the trace: %s", line);
          failCount++;
        end
      end else if (line[0] == "C") begin
        fields = $sscanf(line, "C %h %h %h %h %h %h %h", fPc, fRegWrite, fWriteReg,
                         fResult, fMemWrite, fDataAddr, fWriteData);
        if (fields == 7) begin
          expPc.push_back(fPc);
          expRegWrite.push_back(fRegWrite);
          expWriteReg.push_back(fWriteReg);
          expResult.push_back(fResult);
          expMemWrite.push_back(fMemWrite);
          expDataAddr.push_back(fDataAddr);
          expWriteData.push_back(fWriteData);
        end else begin
          $display("malformed cycle line in the trace: %s", line);
          failCount++;
        end
      end
    end
    $fclose(fd);
    if (expPc.size() == 0) begin
      $display("the trace holds no cycle lines");
      failCount++;
    end
    ok = (expPc.size() > 0);
  endtask

  // ====================
  // checks
  // ====================
  task automatic checkField(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      $display("[ERROR] cycle %0d %s: expected %h, got %h", cycleIdx, name, expected, actual);
      errorCount++;
    end
  endtask

  // write port values count only while their enable is expected high
  task automatic checkCycle(input int idx);
    checkField("pc", expPc[idx], pc);
    checkField("regWrite", expRegWrite[idx], 32'(regWrite));
    if (expRegWrite[idx][0]) begin
      checkField("writeReg", expWriteReg[idx], 32'(writeReg));
      checkField("result", expResult[idx], result);
    end
    checkField("memWrite", expMemWrite[idx], 32'(memWrite));
    if (expMemWrite[idx][0]) begin
      checkField("dataAddr", expDataAddr[idx], dataAddr);
      checkField("writeData", expWriteData[idx], writeData);
    end
  endtask

  // ====================
  // reset and run
  // ====================
  task automatic applyReset(output bit ok);
    int waitCycles;
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #driveDelay;
    rstN = 1'b1;
    waitCycles = 0;
    while (pc !== '0 && waitCycles < resetTimeout) begin
      @(posedge clk);
      #driveDelay;
      waitCycles++;
    end
    ok = (pc === '0);
    if (!ok) begin
      $display("pc did not clear to zero within %0d cycles of reset", resetTimeout);
      failCount++;
    end
  endtask

  // entered a short delay after a rising edge; checks land just before the next one
  task automatic runTrace();
    int cycleCount;
    cycleCount = 0;
    cycleIdx = 0;
    while (cycleIdx < expPc.size() && cycleCount < maxCycles) begin
      instr = progImage[pc[progAddrBits+1:2]];
      #(clkPeriod - driveDelay - 2);
      checkCycle(cycleIdx);
      cycleIdx++;
      cycleCount++;
      @(posedge clk);
      #driveDelay;
    end
    if (cycleIdx < expPc.size()) begin
      $display("trace stalled at cycle %0d of %0d after %0d clock cycles",
               cycleIdx, expPc.size(), cycleCount);
      failCount++;
    end
  endtask

  initial begin : mainFlow
    bit loadOk;
    bit resetOk;
    rstN = 1'b0;
    // all ones is no valid opcode, so the core idles until the program starts
    instr = '1;
    resetOk = 1'b0;
    loadTrace(loadOk);
    if (loadOk) begin
      applyReset(resetOk);
    end
    if (resetOk) begin
      runTrace();
    end
    $display("%0d checks, %0d value errors, %0d other failures",
             checkCount, errorCount, failCount);
    if (errorCount == 0 && failCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/programTrace.txt
# P <word address> <instruction word>
# C <pc> <regWrite> <writeReg> <result> <memWrite> <dataAddr> <writeData>, all hex
# writeReg and result count only when regWrite is 1, dataAddr and writeData only when memWrite is 1
P 00 20010005   # addi r1, r0, 5
P 01 2002000C   # addi r2, r0, 12
P 02 2003FFFD   # addi r3, r0, -3
P 03 00222020   # add  r4, r1, r2
P 04 00412822   # sub  r5, r2, r1
P 05 00223024   # and  r6, r1, r2
P 06 00223825   # or   r7, r1, r2
P 07 0061402A   # slt  r8, r3, r1
P 08 0023482A   # slt  r9, r1, r3
P 09 AC440008   # sw   r4, 8(r2)
P 0A 8C4A0008   # lw   r10, 8(r2)
P 0B 108A0002   # beq  r4, r10, +2 (taken)
P 0C 200B07FF   # skipped
P 0D 200D0001   # skipped
P 0E 10220003   # beq  r1, r2, +3 (not taken)
P 0F 08000000   # j 0, unsupported, runs as a nop
P 10 FC432000   # unknown opcode
P 11 20000063   # addi r0, r0, 99
P 12 00075820   # add  r11, r0, r7
P 13 00206020   # add  r12, r1, r0
P 14 AC0C0000   # sw   r12, 0(r0)
P 15 1000FFFF   # beq  r0, r0, -1 (spins in place)
C 00000000 1 01 00000005 0 00000000 00000000
C 00000004 1 02 0000000C 0 00000000 00000000
C 00000008 1 03 FFFFFFFD 0 00000000 00000000
C 0000000C 1 04 00000011 0 00000000 00000000
C 00000010 1 05 00000007 0 00000000 00000000
C 00000014 1 06 00000004 0 00000000 00000000
C 00000018 1 07 0000000D 0 00000000 00000000
C 0000001C 1 08 00000001 0 00000000 00000000
C 00000020 1 09 00000000 0 00000000 00000000
C 00000024 0 00 00000000 1 00000014 00000011
C 00000028 1 0A 00000011 0 00000000 00000000
C 0000002C 0 00 00000000 0 00000000 00000000
C 00000038 0 00 00000000 0 00000000 00000000
C 0000003C 0 00 00000000 0 00000000 00000000
C 00000040 0 00 00000000 0 00000000 00000000
C 00000044 1 00 00000063 0 00000000 00000000
C 00000048 1 0B 0000000D 0 00000000 00000000
C 0000004C 1 0C 00000005 0 00000000 00000000
C 00000050 0 00 00000000 1 00000000 00000005
C 00000054 0 00 00000000 0 00000000 00000000
C 00000054 0 00 00000000 0 00000000 00000000

//--- all.f
common/mipsPkg.sv
control/controlUnit.sv
datapath/registerFile.sv
datapath/alu.sv
datapath/dataPath.sv
source/dataMemory.sv
source/mipsCore.sv
tests/mipsCoreTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mipsCoreTb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = *** FAILED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
